// File: term_pkg.sv
package term_pkg;

  // Glyph cell geometry
  localparam int FONT_W = 8;
  localparam int FONT_H = 8;

  localparam int CHAR_W = 8;

  // PS/2 set 2 scan codes with special meaning
  localparam logic [7:0] SC_BREAK = 8'hF0;
  localparam logic [7:0] SC_ENTER = 8'h5A;

  localparam logic [CHAR_W-1:0] ASCII_SPACE = 8'h20; // Buffer clear value
  localparam logic [CHAR_W-1:0] ASCII_ENTER = 8'h0D;

  typedef enum logic [1:0] {
    IDLE,
    DATA,
    PARITY,
    STOP
  } ps2_state_t;

  typedef enum logic {
    MAKE,
    BREAK
  } key_state_t;

endpackage

// File: ps2_rx.sv
module ps2_rx (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       ps2_clk,
  input  logic       ps2_data,
  output logic [7:0] code,
  output logic       code_valid
);

  logic [2:0] clk_sync;  // Two sync stages plus one for edge detect
  logic [1:0] data_sync;
  logic       fall;
  logic       bit_in;
  logic [7:0] shift;
  logic [2:0] bit_cnt;
  logic       parity_ok;
  term_pkg::ps2_state_t state;

  assign fall   = clk_sync[2] & ~clk_sync[1];
  assign bit_in = data_sync[1];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      clk_sync  <= '1;  // Lines idle high
      data_sync <= '1;
    end else begin
      clk_sync  <= {clk_sync[1:0], ps2_clk};
      data_sync <= {data_sync[0], ps2_data};
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= term_pkg::IDLE;
      bit_cnt    <= '0;
      parity_ok  <= 1'b0;
      code_valid <= 1'b0;
    end else begin
      code_valid <= 1'b0;
      if (fall) begin
        case (state)
          term_pkg::IDLE: begin
            bit_cnt <= '0;
            if (!bit_in)
              state <= term_pkg::DATA;  // Start bit is low
          end
          term_pkg::DATA: begin
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7)
              state <= term_pkg::PARITY;
          end
          term_pkg::PARITY: begin
            parity_ok <= ^{shift, bit_in};  // Odd parity
            state     <= term_pkg::STOP;
          end
          term_pkg::STOP: begin
            code_valid <= parity_ok & bit_in;
            state      <= term_pkg::IDLE;
          end
          default: state <= term_pkg::IDLE;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fall && state == term_pkg::DATA)
      shift <= {bit_in, shift[7:1]};  // LSB first
    if (fall && state == term_pkg::STOP)
      code <= shift;
  end

endmodule

// File: key_decoder.sv
module key_decoder #(
  parameter int COLS = 80,
  parameter int ROWS = 60
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [7:0]                    code,
  input  logic                          code_valid,
  output logic                          wr_req,
  output logic [$clog2(COLS*ROWS)-1:0]  wr_addr,
  output logic [term_pkg::CHAR_W-1:0]   wr_data,
  input  logic                          wr_ack
);

  localparam int ADDR_W = $clog2(COLS * ROWS);
  localparam int COL_W  = $clog2(COLS);
  localparam int ROW_W  = $clog2(ROWS);

  term_pkg::key_state_t        state;
  logic [COL_W-1:0]            col;
  logic [ROW_W-1:0]            row;
  logic [ROW_W-1:0]            row_next;
  logic [term_pkg::CHAR_W-1:0] ascii;

  assign row_next = (row == ROW_W'(ROWS - 1)) ? '0 : row + 1'b1;  // No scrolling, wrap

  always_comb begin
    case (code)
      8'h1C: ascii = "a";
      8'h32: ascii = "b";
      8'h21: ascii = "c";
      8'h23: ascii = "d";
      8'h24: ascii = "e";
      8'h2B: ascii = "f";
      8'h34: ascii = "g";
      8'h33: ascii = "h";
      8'h43: ascii = "i";
      8'h3B: ascii = "j";
      8'h42: ascii = "k";
      8'h4B: ascii = "l";
      8'h3A: ascii = "m";
      8'h31: ascii = "n";
      8'h44: ascii = "o";
      8'h4D: ascii = "p";
      8'h15: ascii = "q";
      8'h2D: ascii = "r";
      8'h1B: ascii = "s";
      8'h2C: ascii = "t";
      8'h3C: ascii = "u";
      8'h2A: ascii = "v";
      8'h1D: ascii = "w";
      8'h22: ascii = "x";
      8'h35: ascii = "y";
      8'h1A: ascii = "z";
      8'h45: ascii = "0";
      8'h16: ascii = "1";
      8'h1E: ascii = "2";
      8'h26: ascii = "3";
      8'h25: ascii = "4";
      8'h2E: ascii = "5";
      8'h36: ascii = "6";
      8'h3D: ascii = "7";
      8'h3E: ascii = "8";
      8'h46: ascii = "9";
      8'h29: ascii = term_pkg::ASCII_SPACE;
      term_pkg::SC_ENTER: ascii = term_pkg::ASCII_ENTER;
      default: ascii = '0;  // Unmapped key
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state  <= term_pkg::MAKE;
      col    <= '0;
      row    <= '0;
      wr_req <= 1'b0;
    end else if (wr_req) begin
      if (wr_ack) begin
        wr_req <= 1'b0;
        if (col == COL_W'(COLS - 1)) begin
          col <= '0;
          row <= row_next;
        end else begin
          col <= col + 1'b1;
        end
      end
    end else if (code_valid) begin
      if (state == term_pkg::BREAK) begin
        state <= term_pkg::MAKE;  // Code of the released key
      end else if (code == term_pkg::SC_BREAK) begin
        state <= term_pkg::BREAK;
      end else if (ascii == term_pkg::ASCII_ENTER) begin
        col <= '0;
        row <= row_next;
      end else if (ascii != '0) begin
        wr_req <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (code_valid && !wr_req) begin
      wr_addr <= ADDR_W'(row * COLS + col);
      wr_data <= ascii;
    end
  end

endmodule

// File: text_arbiter.sv
module text_arbiter #(
  parameter int DEPTH = 4800
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         wr_req,
  input  logic [$clog2(DEPTH)-1:0]     wr_addr,
  input  logic [term_pkg::CHAR_W-1:0]  wr_data,
  output logic                         wr_ack,
  input  logic                         rd_req,
  input  logic [$clog2(DEPTH)-1:0]     rd_addr,
  output logic [term_pkg::CHAR_W-1:0]  rd_data
);

  localparam int ADDR_W = $clog2(DEPTH);

  logic [term_pkg::CHAR_W-1:0] mem [DEPTH];
  logic                        clearing;
  logic [ADDR_W-1:0]           clr_addr;
  logic                        we;
  logic [ADDR_W-1:0]           waddr;
  logic [term_pkg::CHAR_W-1:0] wdata;

  assign wr_ack = wr_req & ~rd_req & ~clearing;  // Raster reads always win
  assign we     = clearing | wr_ack;
  assign waddr  = clearing ? clr_addr : wr_addr;
  assign wdata  = clearing ? term_pkg::ASCII_SPACE : wr_data;

  // One cell per cycle until the whole screen holds spaces
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      clearing <= 1'b1;
      clr_addr <= '0;
    end else if (clearing) begin
      clr_addr <= clr_addr + 1'b1;
      if (clr_addr == ADDR_W'(DEPTH - 1))
        clearing <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (we)
      mem[waddr] <= wdata;
    if (clearing)
      rd_data <= term_pkg::ASCII_SPACE;  // Reads suppressed during the sweep
    else if (rd_req)
      rd_data <= mem[rd_addr];
  end

endmodule

// File: vga_timing.sv
module vga_timing #(
  parameter int H_ACTIVE = 640,
  parameter int H_FRONT  = 16,
  parameter int H_SYNC   = 96,
  parameter int H_BACK   = 48,
  parameter int V_ACTIVE = 480,
  parameter int V_FRONT  = 10,
  parameter int V_SYNC   = 2,
  parameter int V_BACK   = 33
) (
  input  logic       clk,
  input  logic       rst_n,
  output logic [9:0] h_cnt,
  output logic [9:0] v_cnt,
  output logic       active,
  output logic       hsync,
  output logic       vsync
);

  localparam int H_TOTAL    = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL    = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
  localparam int H_SYNC_BEG = H_ACTIVE + H_FRONT;
  localparam int V_SYNC_BEG = V_ACTIVE + V_FRONT;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (h_cnt == 10'(H_TOTAL - 1)) begin
      h_cnt <= '0;
      if (v_cnt == 10'(V_TOTAL - 1))
        v_cnt <= '0;
      else
        v_cnt <= v_cnt + 10'd1;
    end else begin
      h_cnt <= h_cnt + 10'd1;
    end
  end

  assign active = (h_cnt < H_ACTIVE) && (v_cnt < V_ACTIVE);
  assign hsync  = !((h_cnt >= H_SYNC_BEG) && (h_cnt < H_SYNC_BEG + H_SYNC));  // Active low
  assign vsync  = !((v_cnt >= V_SYNC_BEG) && (v_cnt < V_SYNC_BEG + V_SYNC));

endmodule

// File: char_render.sv
module char_render #(
  parameter int COLS = 80,
  parameter int ROWS = 60
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [9:0]                    h_cnt,
  input  logic [9:0]                    v_cnt,
  input  logic                          active,
  input  logic                          hsync,
  input  logic                          vsync,
  output logic                          rd_req,
  output logic [$clog2(COLS*ROWS)-1:0]  rd_addr,
  input  logic [term_pkg::CHAR_W-1:0]   rd_data,
  output logic                          vga_hsync,
  output logic                          vga_vsync,
  output logic                          vga_blank_n,
  output logic [7:0]                    vga_r,
  output logic [7:0]                    vga_g,
  output logic [7:0]                    vga_b
);

  localparam int ADDR_W  = $clog2(COLS * ROWS);
  localparam int FW      = term_pkg::FONT_W;
  localparam int FH      = term_pkg::FONT_H;
  localparam int PX_W    = $clog2(FW);
  localparam int PY_W    = $clog2(FH);

  logic [FW*FH-1:0] font_rom [128];  // Top row in the upper byte
  logic [FW*FH-1:0] glyph;
  logic [PX_W-1:0]  px1, px2;
  logic [PY_W-1:0]  py1;
  logic [FW-1:0]    row_bits;
  logic [2:0]       hs_d, vs_d, act_d;
  logic             pix;

  initial $readmemh("font.hex", font_rom);

  assign rd_req  = active;
  assign rd_addr = ADDR_W'((v_cnt / FH) * COLS + h_cnt / FW);
  assign glyph   = font_rom[rd_data[6:0]];

  always_ff @(posedge clk) begin
    px1      <= h_cnt[PX_W-1:0];
    py1      <= v_cnt[PY_W-1:0];
    px2      <= px1;
    row_bits <= glyph[(FH - 1 - py1) * FW +: FW];
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      hs_d  <= '1;
      vs_d  <= '1;
      act_d <= '0;
      pix   <= 1'b0;
    end else begin
      hs_d  <= {hs_d[1:0], hsync};
      vs_d  <= {vs_d[1:0], vsync};
      act_d <= {act_d[1:0], active};
      pix   <= act_d[1] & row_bits[FW - 1 - px2];  // Leftmost pixel is the MSB
    end
  end

  assign vga_hsync   = hs_d[2];
  assign vga_vsync   = vs_d[2];
  assign vga_blank_n = act_d[2];
  assign vga_r       = {8{pix}};
  assign vga_g       = {8{pix}};
  assign vga_b       = {8{pix}};

endmodule

// File: term_top.sv
module term_top #(
  parameter int H_ACTIVE = 640,
  parameter int H_FRONT  = 16,
  parameter int H_SYNC   = 96,
  parameter int H_BACK   = 48,
  parameter int V_ACTIVE = 480,
  parameter int V_FRONT  = 10,
  parameter int V_SYNC   = 2,
  parameter int V_BACK   = 33
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       ps2_clk,
  input  logic       ps2_data,
  output logic       vga_hsync,
  output logic       vga_vsync,
  output logic       vga_blank_n,
  output logic [7:0] vga_r,
  output logic [7:0] vga_g,
  output logic [7:0] vga_b
);

  localparam int COLS   = H_ACTIVE / term_pkg::FONT_W;
  localparam int ROWS   = V_ACTIVE / term_pkg::FONT_H;
  localparam int ADDR_W = $clog2(COLS * ROWS);

  logic [7:0]                  code;
  logic                        code_valid;
  logic                        wr_req;
  logic                        wr_ack;
  logic [ADDR_W-1:0]           wr_addr;
  logic [term_pkg::CHAR_W-1:0] wr_data;
  logic                        rd_req;
  logic [ADDR_W-1:0]           rd_addr;
  logic [term_pkg::CHAR_W-1:0] rd_data;
  logic [9:0]                  h_cnt;
  logic [9:0]                  v_cnt;
  logic                        active;
  logic                        hsync;
  logic                        vsync;

  ps2_rx u_ps2_rx (
    .clk        (clk),
    .rst_n      (rst_n),
    .ps2_clk    (ps2_clk),
    .ps2_data   (ps2_data),
    .code       (code),
    .code_valid (code_valid)
  );

  key_decoder #(
    .COLS (COLS),
    .ROWS (ROWS)
  ) u_key_decoder (
    .clk        (clk),
    .rst_n      (rst_n),
    .code       (code),
    .code_valid (code_valid),
    .wr_req     (wr_req),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .wr_ack     (wr_ack)
  );

  text_arbiter #(
    .DEPTH (COLS * ROWS)
  ) u_text_arbiter (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_req  (wr_req),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .wr_ack  (wr_ack),
    .rd_req  (rd_req),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  vga_timing #(
    .H_ACTIVE (H_ACTIVE),
    .H_FRONT  (H_FRONT),
    .H_SYNC   (H_SYNC),
    .H_BACK   (H_BACK),
    .V_ACTIVE (V_ACTIVE),
    .V_FRONT  (V_FRONT),
    .V_SYNC   (V_SYNC),
    .V_BACK   (V_BACK)
  ) u_vga_timing (
    .clk    (clk),
    .rst_n  (rst_n),
    .h_cnt  (h_cnt),
    .v_cnt  (v_cnt),
    .active (active),
    .hsync  (hsync),
    .vsync  (vsync)
  );

  char_render #(
    .COLS (COLS),
    .ROWS (ROWS)
  ) u_char_render (
    .clk         (clk),
    .rst_n       (rst_n),
    .h_cnt       (h_cnt),
    .v_cnt       (v_cnt),
    .active      (active),
    .hsync       (hsync),
    .vsync       (vsync),
    .rd_req      (rd_req),
    .rd_addr     (rd_addr),
    .rd_data     (rd_data),
    .vga_hsync   (vga_hsync),
    .vga_vsync   (vga_vsync),
    .vga_blank_n (vga_blank_n),
    .vga_r       (vga_r),
    .vga_g       (vga_g),
    .vga_b       (vga_b)
  );

endmodule

// File: tb_checker.sv
module tb_checker #(
  parameter int H_ACTIVE = 640,
  parameter int H_FRONT  = 16,
  parameter int H_SYNC   = 96,
  parameter int H_BACK   = 48,
  parameter int V_ACTIVE = 480,
  parameter int V_FRONT  = 10,
  parameter int V_SYNC   = 2,
  parameter int V_BACK   = 33
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       vga_hsync,
  input  logic       vga_vsync,
  input  logic       vga_blank_n,
  input  logic [7:0] vga_r,
  input  logic [7:0] vga_g,
  input  logic [7:0] vga_b,
  input  logic [1:0] entry_eff,
  input  logic [7:0] entry_ascii,
  output int         tests_done,
  output int         tests_failed,
  output int         errors
);

  localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
  localparam int COLS    = H_ACTIVE / 8;
  localparam int ROWS    = V_ACTIVE / 8;
  localparam logic [1:0] EFF_CHAR  = 2'd1;
  localparam logic [1:0] EFF_ENTER = 2'd2;
  localparam int MAX_REPORTS = 20;

  event key_ev;  // One per applied table entry

  logic [63:0] font [128];
  logic [7:0]  model [COLS*ROWS];
  int          col, row;
  int          x, y;
  int          hs_per, hs_low, vs_per, vs_low;
  logic        hs_seen, vs_seen;
  logic        prev_hs, prev_vs, prev_blank;
  int          test_id, test_err, frames_left;
  logic        test_open;
  logic [7:0]  exp_px;

  function automatic logic [7:0] expected_pixel(input int px, input int py);
    logic [63:0] glyph;
    glyph = font[model[(py / 8) * COLS + px / 8]];
    return glyph[(7 - py % 8) * 8 + (7 - px % 8)] ? 8'hFF : 8'h00;
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      errors++;
      test_err++;
      if (errors <= MAX_REPORTS)
        $display("CHECK FAILED %s: expected %h, got %h (x=%0d y=%0d)", name, exp, act, x, y);
    end
  endtask

  initial begin
    $readmemh("font.hex", font);
    for (int i = 0; i < COLS * ROWS; i++)
      model[i] = 8'h20;  // Screen starts cleared to spaces
    col          = 0;
    row          = 0;
    test_id      = 0;
    test_err     = 0;
    frames_left  = 2;  // Test 0 covers the first two frames after reset
    test_open    = 1'b1;
    tests_done   = 0;
    tests_failed = 0;
    errors       = 0;
  end

  always @(key_ev) begin
    if (entry_eff == EFF_CHAR) begin
      model[row * COLS + col] = entry_ascii;
      col++;
    end else if (entry_eff == EFF_ENTER) begin
      col = COLS;
    end
    if (col == COLS) begin
      col = 0;
      row = (row == ROWS - 1) ? 0 : row + 1;  // Wraps to the top row
    end
    test_id++;
    test_err    = 0;
    frames_left = 1;
    test_open   = 1'b1;
  end

  always @(negedge clk) begin
    if (!rst_n) begin
      x          = 0;
      y          = 0;
      hs_per     = 0;
      hs_low     = 0;
      vs_per     = 0;
      vs_low     = 0;
      hs_seen    = 1'b0;
      vs_seen    = 1'b0;
      prev_hs    = 1'b1;
      prev_vs    = 1'b1;
      prev_blank = 1'b0;
    end else begin
      hs_per++;
      vs_per++;
      if (!vga_hsync)
        hs_low++;
      if (!vga_vsync)
        vs_low++;
      if (vga_blank_n) begin
        exp_px = expected_pixel(x, y);
        check_val("vga_r", exp_px, vga_r);
        check_val("vga_g", exp_px, vga_g);
        check_val("vga_b", exp_px, vga_b);
        x++;
      end else begin
        check_val("vga_r", 0, vga_r);  // Black outside the active area
        check_val("vga_g", 0, vga_g);
        check_val("vga_b", 0, vga_b);
      end
      // Sync pulse plus back porch before each active line and frame
      if (!prev_blank && vga_blank_n) begin
        if (hs_seen)
          check_val("vga_hsync to active start", H_SYNC + H_BACK, hs_per);
        if (vs_seen && y == 0)
          check_val("vga_vsync to active start", (V_SYNC + V_BACK) * H_TOTAL, vs_per);
      end
      if (prev_blank && !vga_blank_n) begin
        check_val("active pixels per line", H_ACTIVE, x);
        x = 0;
        y++;
      end
      if (prev_hs && !vga_hsync) begin
        if (hs_seen)
          check_val("vga_hsync period", H_TOTAL, hs_per);
        hs_seen = 1'b1;
        hs_per  = 0;
      end
      if (!prev_hs && vga_hsync) begin
        check_val("vga_hsync low width", H_SYNC, hs_low);
        hs_low = 0;
      end
      if (!prev_vs && vga_vsync) begin
        check_val("vga_vsync low width", V_SYNC * H_TOTAL, vs_low);
        vs_low = 0;
      end
      if (prev_vs && !vga_vsync) begin
        if (vs_seen)
          check_val("vga_vsync period", V_TOTAL * H_TOTAL, vs_per);
        check_val("active lines per frame", V_ACTIVE, y);
        vs_seen = 1'b1;
        vs_per  = 0;
        y       = 0;
        if (test_open) begin
          frames_left--;
          if (frames_left == 0) begin
            test_open = 1'b0;
            tests_done++;
            if (test_err != 0)
              tests_failed++;
            $display("test %0d: %s, %0d mismatches", test_id,
                     (test_err == 0) ? "ok" : "failed", test_err);
          end
        end
      end
      prev_hs    = vga_hsync;
      prev_vs    = vga_vsync;
      prev_blank = vga_blank_n;
    end
  end

endmodule

// File: tb_top.sv
module tb_top;

  // Tiny screen of 10 columns by 6 rows
  localparam int H_ACTIVE = 80;
  localparam int H_FRONT  = 4;
  localparam int H_SYNC   = 8;
  localparam int H_BACK   = 4;
  localparam int V_ACTIVE = 48;
  localparam int V_FRONT  = 2;
  localparam int V_SYNC   = 2;
  localparam int V_BACK   = 2;
  localparam int FRAME_CYCLES =
    (H_ACTIVE + H_FRONT + H_SYNC + H_BACK) * (V_ACTIVE + V_FRONT + V_SYNC + V_BACK);
  localparam int PS2_HALF = 4;   // System clocks per PS/2 clock phase
  localparam int N_RANDOM = 21;  // Enough to fill the last rows and wrap to cell 0
  localparam logic [1:0] EFF_NONE  = 2'd0;
  localparam logic [1:0] EFF_CHAR  = 2'd1;
  localparam logic [1:0] EFF_ENTER = 2'd2;

  logic       clk;
  logic       rst_n;
  logic       ps2_clk;
  logic       ps2_data;
  logic       vga_hsync, vga_vsync, vga_blank_n;
  logic [7:0] vga_r, vga_g, vga_b;

  logic [7:0]  tab_code[$];
  logic        tab_bad[$];
  logic [1:0]  tab_eff[$];
  logic [7:0]  tab_ascii[$];
  logic [1:0]  cur_eff;
  logic [7:0]  cur_ascii;
  logic [31:0] rnd;
  int          tests_done, tests_failed, errors;

  always #10 clk = ~clk;

  term_top #(
    .H_ACTIVE (H_ACTIVE),
    .H_FRONT  (H_FRONT),
    .H_SYNC   (H_SYNC),
    .H_BACK   (H_BACK),
    .V_ACTIVE (V_ACTIVE),
    .V_FRONT  (V_FRONT),
    .V_SYNC   (V_SYNC),
    .V_BACK   (V_BACK)
  ) u_term_top (
    .clk         (clk),
    .rst_n       (rst_n),
    .ps2_clk     (ps2_clk),
    .ps2_data    (ps2_data),
    .vga_hsync   (vga_hsync),
    .vga_vsync   (vga_vsync),
    .vga_blank_n (vga_blank_n),
    .vga_r       (vga_r),
    .vga_g       (vga_g),
    .vga_b       (vga_b)
  );

  tb_checker #(
    .H_ACTIVE (H_ACTIVE),
    .H_FRONT  (H_FRONT),
    .H_SYNC   (H_SYNC),
    .H_BACK   (H_BACK),
    .V_ACTIVE (V_ACTIVE),
    .V_FRONT  (V_FRONT),
    .V_SYNC   (V_SYNC),
    .V_BACK   (V_BACK)
  ) u_tb_checker (
    .clk          (clk),
    .rst_n        (rst_n),
    .vga_hsync    (vga_hsync),
    .vga_vsync    (vga_vsync),
    .vga_blank_n  (vga_blank_n),
    .vga_r        (vga_r),
    .vga_g        (vga_g),
    .vga_b        (vga_b),
    .entry_eff    (cur_eff),
    .entry_ascii  (cur_ascii),
    .tests_done   (tests_done),
    .tests_failed (tests_failed),
    .errors       (errors)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic add_entry(input logic [7:0] sc, input logic bad, input logic [1:0] eff,
                           input logic [7:0] ascii);
    tab_code.push_back(sc);
    tab_bad.push_back(bad);
    tab_eff.push_back(eff);
    tab_ascii.push_back(ascii);
  endtask

  task automatic build_table();
    add_entry(8'h1C, 1'b0, EFF_CHAR, "a");
    add_entry(8'h32, 1'b0, EFF_CHAR, "b");
    add_entry(8'h16, 1'b0, EFF_CHAR, "1");
    add_entry(8'hF0, 1'b0, EFF_NONE, 8'h00);  // Release of a
    add_entry(8'h1C, 1'b0, EFF_NONE, 8'h00);
    add_entry(8'h5A, 1'b0, EFF_ENTER, 8'h00);
    add_entry(8'h5A, 1'b0, EFF_ENTER, 8'h00);
    add_entry(8'h5A, 1'b0, EFF_ENTER, 8'h00);
    add_entry(8'h5A, 1'b0, EFF_ENTER, 8'h00);
    add_entry(8'h2C, 1'b1, EFF_NONE, 8'h00);  // Corrupted t
    add_entry(8'h1A, 1'b0, EFF_CHAR, "z");
    for (int i = 0; i < N_RANDOM; i++) begin
      rnd = lcg_next(rnd);
      case (rnd[29:28])
        2'd0: add_entry(8'h29, 1'b0, EFF_CHAR, 8'h20);
        2'd1: add_entry(8'h1C, 1'b0, EFF_CHAR, "a");
        2'd2: add_entry(8'h46, 1'b0, EFF_CHAR, "9");
        default: add_entry(8'h3A, 1'b0, EFF_CHAR, "m");
      endcase
    end
  endtask

  // Start bit, 8 data bits LSB first, odd parity, stop bit
  task automatic send_ps2(input logic [7:0] sc, input logic bad_parity);
    logic [10:0] frame;
    frame = {1'b1, (~^sc) ^ bad_parity, sc, 1'b0};
    for (int i = 0; i < 11; i++) begin
      ps2_data = frame[i];
      repeat (PS2_HALF) @(negedge clk);
      ps2_clk = 1'b0;
      repeat (PS2_HALF) @(negedge clk);
      ps2_clk = 1'b1;
    end
  endtask

  task automatic wait_vsync_fall();
    logic prev;
    logic found;
    int   n;
    @(negedge clk);
    prev  = vga_vsync;
    found = 1'b0;
    n     = 0;
    while (!found && n < FRAME_CYCLES + 200) begin
      @(negedge clk);
      found = prev && !vga_vsync;
      prev  = vga_vsync;
      n++;
    end
    if (!found) begin
      $display("timeout: no falling edge on vga_vsync within one frame");
      $display("SIMULATION FAILED");
      $finish;
    end
  endtask

  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    ps2_clk   = 1'b1;
    ps2_data  = 1'b1;
    cur_eff   = EFF_NONE;
    cur_ascii = 8'h00;
    rnd       = 32'h371b;
    build_table();
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    wait_vsync_fall();
    wait_vsync_fall();
    // Each key is sent in vertical blanking so the next frame shows its effect
    for (int i = 0; i < tab_code.size(); i++) begin
      send_ps2(tab_code[i], tab_bad[i]);
      cur_eff   = tab_eff[i];
      cur_ascii = tab_ascii[i];
      @(posedge clk);
      -> u_tb_checker.key_ev;
      wait_vsync_fall();
    end
    @(negedge clk);
    $display("%0d tests run, %0d failed, %0d errors", tests_done, tests_failed, errors);
    if (errors == 0 && tests_failed == 0 && tests_done == tab_code.size() + 1) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: font.hex
// One 64-bit glyph per ASCII address, top pixel row in the upper byte
// Within a row byte the leftmost pixel is the MSB
@20
0000000000000000 // space
@30
3C666E7666663C00 // 0
1838181818187E00
3C66060C30607E00
3C66061C06663C00
0C1C3C6C7E0C0C00
7E607C0606663C00
3C607C6666663C00
7E060C1830303000
3C66663C66663C00
3C66663E060C3800 // 9
@61
00003C063E663E00 // a
60607C6666667C00
00003C6060603C00
06063E6666663E00
00003C667E603C00
1C307C3030303000
00003E66663E067C
60607C6666666600
1800381818183C00
0C001C0C0C0C6C38
6060666C786C6600
3818181818183C00
0000667F7F6B6300
00007C6666666600
00003C6666663C00
00007C66667C6060
00003E66663E0606
00007C6660606000
00003E603C067C00
30307C3030301C00
0000666666663E00
00006666663C1800
0000636B7F3E3600
0000663C183C6600
00006666663E0C78
00007E0C18307E00 // z

// File: all.f
term_pkg.sv
ps2_rx.sv
key_decoder.sv
text_arbiter.sv
vga_timing.sv
char_render.sv
term_top.sv
tb_checker.sv
tb_top.sv
